// ==== rtl/upCpu_consts.svh ====
`ifndef UP_CPU_CONSTS_SVH
`define UP_CPU_CONSTS_SVH

// datapath and bus widths
`define UP_DATA_W 8
`define UP_ADDR_W 8

// byte shown on the result port
`define UP_RESULT_ADDR 127

// wake-up delay after reset
`define UP_WAKE_CYCLES 5
`define UP_WAKE_W 4 // counter width, must hold UP_WAKE_CYCLES

`endif

// ==== rtl/upPkg.sv ====
`include "upCpu_consts.svh"

package upPkg;

	// ========================================
	// instruction set in the upper nibble of the opcode byte
	// ========================================
	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_LDI = 4'h1, // acc = operand
		OP_LDA = 4'h2, // acc = mem[operand]
		OP_STA = 4'h3, // mem[operand] = acc
		OP_ADD = 4'h4,
		OP_SUB = 4'h5,
		OP_AND = 4'h6,
		OP_OR  = 4'h7,
		OP_XOR = 4'h8,
		OP_SHL = 4'h9,
		OP_SHR = 4'hA,
		OP_JMP = 4'hB,
		OP_JZ  = 4'hC,
		OP_JC  = 4'hD,
		OP_HLT = 4'hE
	} opcodeT; // 4'hF has no name and runs as NOP

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		OPERAND,
		EXECUTE,
		HALT
	} seqStateT;

	// ========================================
	// boot image
	// ========================================
	// sums three data bytes, stores to the result byte, halts
	function automatic logic [`UP_DATA_W-1:0] bootByte(input logic [`UP_ADDR_W-1:0] addr);
		case (addr)
			8'h00: bootByte = {OP_LDA, 4'h0};
			8'h01: bootByte = 8'h40;
			8'h02: bootByte = {OP_ADD, 4'h0};
			8'h03: bootByte = 8'h41;
			8'h04: bootByte = {OP_ADD, 4'h0};
			8'h05: bootByte = 8'h42;
			8'h06: bootByte = {OP_STA, 4'h0};
			8'h07: bootByte = `UP_DATA_W'(`UP_RESULT_ADDR);
			8'h08: bootByte = {OP_HLT, 4'h0};
			8'h09: bootByte = 8'h00;
			// data bytes
			8'h40: bootByte = 8'h5A;
			8'h41: bootByte = 8'hC3; // wraps, sets carry on the way
			8'h42: bootByte = 8'h17;
			default: bootByte = 8'h00;
		endcase
	endfunction

endpackage

// ==== rtl/upMemory.sv ====
`timescale 1ns/1ps
`include "upCpu_consts.svh"

module upMemory (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic [`UP_DATA_W-1:0] wrData,
	input  logic [`UP_ADDR_W-1:0] address,
	input  logic                  we,
	output logic [`UP_DATA_W-1:0] rdData,
	output logic                  ready,
	output logic [`UP_DATA_W-1:0] result
);
	import upPkg::*;

	localparam int Depth = 1 << `UP_ADDR_W;

	logic [`UP_DATA_W-1:0] mem [Depth];
	logic [`UP_WAKE_W-1:0] wakeCount;

	// ========================================
	// storage
	// ========================================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			// reset reloads the whole boot image
			for (int i = 0; i < Depth; i++) begin
				mem[i] <= bootByte(`UP_ADDR_W'(i));
			end
		end else if (we) begin
			mem[address] <= wrData;
		end
	end

	assign rdData = mem[address]; // async read
	assign result = mem[`UP_RESULT_ADDR];

	// ========================================
	// wake-up counter
	// ========================================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			wakeCount <= '0;
		end else if (wakeCount != `UP_WAKE_W'(`UP_WAKE_CYCLES)) begin
			wakeCount <= wakeCount + 1'b1; // saturates at the limit
		end
	end

	assign ready = (wakeCount == `UP_WAKE_W'(`UP_WAKE_CYCLES));

endmodule

// ==== rtl/upFetchUnit.sv ====
`timescale 1ns/1ps
`include "upCpu_consts.svh"

module upFetchUnit (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic [`UP_DATA_W-1:0] memRdData,
	input  logic                  latchOpcode,
	input  logic                  latchOperand,
	input  logic                  jumpTaken,
	input  logic                  clearPc,
	output logic [`UP_ADDR_W-1:0] pc,
	output logic [`UP_DATA_W-1:0] operand,
	output upPkg::opcodeT         opcode,
	output logic                  isStore,
	output logic                  isJump
);
	import upPkg::*;

	logic [3:0] opNibble;

	// program counter
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
		end else if (clearPc) begin
			pc <= '0;
		end else if (jumpTaken) begin
			pc <= operand;
		end else if (latchOpcode || latchOperand) begin
			pc <= pc + 1'b1;
		end
	end

	// instruction registers
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			opNibble <= OP_NOP;
		end else if (latchOpcode) begin
			opNibble <= memRdData[`UP_DATA_W-1 -: 4];
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			operand <= '0;
		end else if (latchOperand) begin
			operand <= memRdData;
		end
	end

	// ========================================
	// decode
	// ========================================
	always_comb begin
		if (opNibble > OP_HLT) begin
			opcode = OP_NOP; // unnamed code
		end else begin
			opcode = opcodeT'(opNibble);
		end
	end

	assign isStore = (opcode == OP_STA);
	assign isJump  = (opcode == OP_JMP) || (opcode == OP_JZ) || (opcode == OP_JC);

endmodule

// ==== rtl/upAccumulator.sv ====
`timescale 1ns/1ps
`include "upCpu_consts.svh"

module upAccumulator (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic                  execute,
	input  upPkg::opcodeT         opcode,
	input  logic [`UP_DATA_W-1:0] operand,
	input  logic [`UP_DATA_W-1:0] memRdData,
	output logic [`UP_DATA_W-1:0] acc,
	output logic                  zero,
	output logic                  carry
);
	import upPkg::*;

	logic [`UP_DATA_W-1:0] accNext;
	logic [`UP_DATA_W:0]   wide; // 9-bit add/sub result
	logic                  carryNext;
	logic                  writesAcc;

	// ========================================
	// ALU
	// ========================================
	always_comb begin
		accNext   = acc;
		carryNext = carry;
		writesAcc = 1'b1;
		wide      = '0;
		case (opcode)
			OP_LDI: accNext = operand;
			OP_LDA: accNext = memRdData;
			OP_ADD: begin
				wide = {1'b0, acc} + {1'b0, memRdData};
				{carryNext, accNext} = wide;
			end
			OP_SUB: begin
				wide = {1'b0, acc} - {1'b0, memRdData};
				{carryNext, accNext} = wide; // top bit is the borrow
			end
			OP_AND: accNext = acc & memRdData;
			OP_OR:  accNext = acc | memRdData;
			OP_XOR: accNext = acc ^ memRdData;
			OP_SHL: begin
				carryNext = acc[`UP_DATA_W-1];
				accNext   = {acc[`UP_DATA_W-2:0], 1'b0};
			end
			OP_SHR: begin
				carryNext = acc[0];
				accNext   = {1'b0, acc[`UP_DATA_W-1:1]};
			end
			default: writesAcc = 1'b0; // STA, jumps, NOP, HLT
		endcase
	end

	// ========================================
	// registers
	// ========================================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc   <= '0;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else if (execute && writesAcc) begin
			acc   <= accNext;
			carry <= carryNext;
			zero  <= (accNext == '0);
		end
	end

endmodule

// ==== rtl/upSequencer.sv ====
`timescale 1ns/1ps
`include "upCpu_consts.svh"

module upSequencer (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic                  ready,
	input  logic                  loadEn,
	input  logic [`UP_ADDR_W-1:0] loadAddr,
	input  logic [`UP_DATA_W-1:0] loadData,
	input  upPkg::opcodeT         opcode,
	input  logic                  isStore,
	input  logic                  isJump,
	input  logic [`UP_ADDR_W-1:0] pc,
	input  logic [`UP_DATA_W-1:0] operand,
	input  logic [`UP_DATA_W-1:0] acc,
	input  logic                  zero,
	input  logic                  carry,
	output logic [`UP_ADDR_W-1:0] memAddr,
	output logic [`UP_DATA_W-1:0] memWrData,
	output logic                  memWe,
	output logic                  latchOpcode,
	output logic                  latchOperand,
	output logic                  execute,
	output logic                  jumpTaken,
	output logic                  clearPc,
	output logic                  halted
);
	import upPkg::*;

	seqStateT state;
	seqStateT stateNext;
	logic     condMet;

	// ========================================
	// state register
	// ========================================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= IDLE;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			IDLE:    if (ready) stateNext = FETCH;
			FETCH:   stateNext = OPERAND;
			OPERAND: stateNext = EXECUTE;
			EXECUTE: stateNext = (opcode == OP_HLT) ? HALT : FETCH;
			HALT:    stateNext = HALT; // only load or reset gets out
			default: stateNext = IDLE;
		endcase
		if (loadEn) begin
			stateNext = IDLE;
		end
	end

	// jump condition from the flags
	always_comb begin
		case (opcode)
			OP_JZ:   condMet = zero;
			OP_JC:   condMet = carry;
			default: condMet = 1'b1; // JMP always goes
		endcase
	end

	// ========================================
	// bus and strobes
	// ========================================
	always_comb begin
		memAddr      = pc;
		memWrData    = acc;
		memWe        = 1'b0;
		latchOpcode  = 1'b0;
		latchOperand = 1'b0;
		execute      = 1'b0;
		jumpTaken    = 1'b0;
		clearPc      = 1'b0;
		if (loadEn) begin
			// load port owns the bus and writes one byte per cycle
			memAddr   = loadAddr;
			memWrData = loadData;
			memWe     = 1'b1;
			clearPc   = 1'b1;
		end else begin
			case (state)
				FETCH:   latchOpcode = 1'b1;
				OPERAND: latchOperand = 1'b1;
				EXECUTE: begin
					memAddr   = operand;
					memWe     = isStore;
					execute   = 1'b1;
					jumpTaken = isJump && condMet;
				end
				default: ;
			endcase
		end
	end

	assign halted = (state == HALT);

endmodule

// ==== rtl/upCpu.sv ====
`timescale 1ns/1ps
`include "upCpu_consts.svh"

module upCpu (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic                  loadEn,
	input  logic [`UP_ADDR_W-1:0] loadAddr,
	input  logic [`UP_DATA_W-1:0] loadData,
	output logic [`UP_DATA_W-1:0] acc,
	output logic                  zero,
	output logic                  carry,
	output logic [`UP_ADDR_W-1:0] pc,
	output logic                  halted,
	output logic [`UP_DATA_W-1:0] result
);
	import upPkg::*;

	// memory bus
	logic [`UP_ADDR_W-1:0] memAddr;
	logic [`UP_DATA_W-1:0] memWrData;
	logic [`UP_DATA_W-1:0] memRdData;
	logic                  memWe;
	logic                  ready;

	// sequencer strobes
	logic latchOpcode;
	logic latchOperand;
	logic execute;
	logic jumpTaken;
	logic clearPc;

	// decoded instruction
	logic [`UP_DATA_W-1:0] operand;
	opcodeT                opcode;
	logic                  isStore;
	logic                  isJump;

	upMemory memory (
		.clk(clk), .nRst(nRst), .wrData(memWrData), .address(memAddr), .we(memWe),
		.rdData(memRdData), .ready(ready), .result(result)
	);

	upFetchUnit fetchUnit (
		.clk(clk), .nRst(nRst), .memRdData(memRdData),
		.latchOpcode(latchOpcode), .latchOperand(latchOperand),
		.jumpTaken(jumpTaken), .clearPc(clearPc), .pc(pc), .operand(operand),
		.opcode(opcode), .isStore(isStore), .isJump(isJump)
	);

	upAccumulator accUnit (
		.clk(clk), .nRst(nRst), .execute(execute), .opcode(opcode), .operand(operand),
		.memRdData(memRdData), .acc(acc), .zero(zero), .carry(carry)
	);

	upSequencer sequencer (
		.clk(clk), .nRst(nRst), .ready(ready), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadData(loadData), .opcode(opcode), .isStore(isStore), .isJump(isJump),
		.pc(pc), .operand(operand), .acc(acc), .zero(zero), .carry(carry),
		.memAddr(memAddr), .memWrData(memWrData), .memWe(memWe),
		.latchOpcode(latchOpcode), .latchOperand(latchOperand), .execute(execute),
		.jumpTaken(jumpTaken), .clearPc(clearPc), .halted(halted)
	);

endmodule

// ==== verif/upCpuModel.svh ====
`ifndef UP_CPU_MODEL_SVH
`define UP_CPU_MODEL_SVH

// ========================================
// instruction-level reference model
// ========================================
localparam int StepLimit = 64;

logic [`UP_DATA_W-1:0] modelMem [256];
logic [`UP_DATA_W-1:0] modelAcc;
logic                  modelZero;
logic                  modelCarry;
logic [`UP_ADDR_W-1:0] modelPc; // pc after the last instruction
int                    modelSteps; // instructions executed, HLT included

// same starting point as a hardware reset
task automatic resetModel();
	for (int i = 0; i < 256; i++) begin
		modelMem[i] = bootByte(8'(i));
	end
	modelAcc   = '0;
	modelZero  = 1'b0;
	modelCarry = 1'b0;
endtask

function automatic void setAcc(logic [`UP_DATA_W-1:0] value);
	modelAcc  = value;
	modelZero = (value == 8'h00);
endfunction

// runs from address 0 until HLT
task automatic interpret();
	logic [3:0] op;
	logic [7:0] arg;
	logic [7:0] data;
	logic [8:0] sum;
	bit         done;
	modelPc    = '0;
	modelSteps = 0;
	done       = 1'b0;
	while (!done && modelSteps < StepLimit) begin
		op   = modelMem[modelPc][7:4];
		arg  = modelMem[8'(modelPc + 1)];
		data = modelMem[arg];
		modelPc = modelPc + 8'd2;
		modelSteps++;
		case (op)
			OP_LDI: setAcc(arg);
			OP_LDA: setAcc(data);
			OP_STA: modelMem[arg] = modelAcc;
			OP_ADD: begin
				sum = 9'(modelAcc) + 9'(data);
				modelCarry = sum[8];
				setAcc(sum[7:0]);
			end
			OP_SUB: begin
				modelCarry = (data > modelAcc); // borrow
				setAcc(modelAcc - data);
			end
			OP_AND: setAcc(modelAcc & data);
			OP_OR:  setAcc(modelAcc | data);
			OP_XOR: setAcc(modelAcc ^ data);
			OP_SHL: begin
				modelCarry = modelAcc[7];
				setAcc(modelAcc << 1);
			end
			OP_SHR: begin
				modelCarry = modelAcc[0];
				setAcc(modelAcc >> 1);
			end
			OP_JMP: modelPc = arg;
			OP_JZ:  if (modelZero) modelPc = arg;
			OP_JC:  if (modelCarry) modelPc = arg;
			OP_HLT: done = 1'b1;
			default: ; // NOP and the unnamed code
		endcase
	end
	if (!done) begin
		failures++;
		$display("model ran %0d instructions without reaching HLT", StepLimit);
	end
endtask

`endif

// ==== verif/upCpuTb.sv ====
`timescale 1ns/1ps
`include "upCpu_consts.svh"

module upCpuTb;
	import upPkg::*;

	logic                  clk;
	logic                  nRst;
	logic                  loadEn;
	logic [`UP_ADDR_W-1:0] loadAddr;
	logic [`UP_DATA_W-1:0] loadData;
	logic [`UP_DATA_W-1:0] acc;
	logic                  zero;
	logic                  carry;
	logic [`UP_ADDR_W-1:0] pc;
	logic                  halted;
	logic [`UP_DATA_W-1:0] result;

	int         seed = 13603;
	int         errors = 0; // value mismatches
	int         failures = 0;
	bit         aborted = 1'b0; // set by a timeout, later waits return at once
	logic [7:0] progAddr [$];
	logic [7:0] progData [$];

	`include "upCpuModel.svh"

	upCpu uut (
		.clk(clk), .nRst(nRst), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.acc(acc), .zero(zero), .carry(carry), .pc(pc), .halted(halted), .result(result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	// counts rising edges, sampled on the falling edge
	task automatic waitForHalt(input int limit, output int cycles);
		cycles = 0;
		if (aborted) return;
		do begin
			@(negedge clk);
			cycles++;
		end while (!halted && cycles < limit);
		if (!halted) begin
			failures++;
			aborted = 1'b1;
			$display("timeout: halted did not rise within %0d cycles", limit);
		end
	endtask

	task automatic checkState();
		checkValue("acc", 32'(acc), 32'(modelAcc));
		checkValue("zero", 32'(zero), 32'(modelZero));
		checkValue("carry", 32'(carry), 32'(modelCarry));
		checkValue("pc", 32'(pc), 32'(modelPc));
		checkValue("result", 32'(result), 32'(modelMem[8'(`UP_RESULT_ADDR)]));
	endtask

	task automatic expectHalt();
		int cycles;
		waitForHalt(3 * StepLimit + 8, cycles);
		if (!aborted) begin
			checkValue("latency", 32'(cycles), 32'(1 + 3 * modelSteps));
			checkState();
		end
	endtask

	task automatic queueByte(input logic [7:0] addr, input logic [7:0] data);
		progAddr.push_back(addr);
		progData.push_back(data);
	endtask

	task automatic queueInstr(input int idx, input opcodeT op, input logic [7:0] arg);
		queueByte(8'(2 * idx), {op, 4'h0});
		queueByte(8'(2 * idx + 1), arg);
	endtask

	// one byte per cycle, loadEn falls after the last one
	task automatic loadProgram();
		foreach (progAddr[i]) begin
			@(negedge clk);
			loadEn   = 1'b1;
			loadAddr = progAddr[i];
			loadData = progData[i];
			modelMem[progAddr[i]] = progData[i];
		end
		@(negedge clk);
		loadEn = 1'b0;
		progAddr.delete();
		progData.delete();
	endtask

	task automatic runProgram();
		loadProgram();
		interpret();
		expectHalt();
	endtask

	// ========================================
	// reset and boot program
	// ========================================
	task automatic resetAndBoot();
		nRst   = 1'b0;
		loadEn = 1'b0;
		repeat (2) @(negedge clk);
		nRst = 1'b1;
		resetModel();
		interpret();
		for (int i = 1; i <= `UP_WAKE_CYCLES; i++) begin
			@(negedge clk);
			checkValue("ready", 32'(uut.ready), 32'(i >= `UP_WAKE_CYCLES));
			checkValue("halted", 32'(halted), 32'(0));
		end
		expectHalt(); // counted from the edge where ready is already high
	endtask

	task automatic randomProgram();
		int         count;
		int         target;
		logic [7:0] opByte;
		logic [7:0] arg;
		count = 2 + int'($unsigned($random(seed)) % 12);
		for (int i = 0; i < count; i++) begin
			opByte = 8'($random(seed));
			arg    = 8'($random(seed));
			case (opByte[7:4])
				OP_JMP, OP_JZ, OP_JC: begin
					target = i + 1 + int'($unsigned($random(seed)) % (count - i)); // forward only
					arg    = 8'(2 * target);
				end
				OP_LDA, OP_STA, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
					arg = (arg[7:5] == 3'd0) ? 8'(`UP_RESULT_ADDR) : {4'h8, arg[3:0]};
				default: ;
			endcase
			queueByte(8'(2 * i), opByte);
			queueByte(8'(2 * i + 1), arg);
		end
		queueInstr(count, OP_HLT, 8'h00);
		for (int d = 0; d < 16; d++) begin
			queueByte(8'(8'h80 + d), 8'($random(seed)));
		end
	endtask

	// ========================================
	// directed programs
	// ========================================
	task automatic directedPrograms();
		queueInstr(0, OP_LDI, 8'hFF); // add wraps to zero
		queueInstr(1, OP_ADD, 8'h80);
		queueInstr(2, OP_HLT, 8'h00);
		queueByte(8'h80, 8'h01);
		runProgram();
		queueInstr(0, OP_LDI, 8'h10); // borrow
		queueInstr(1, OP_SUB, 8'h80);
		queueInstr(2, OP_HLT, 8'h00);
		queueByte(8'h80, 8'h20);
		runProgram();
		queueInstr(0, OP_LDI, 8'h81);
		queueInstr(1, OP_SHL, 8'h00);
		queueInstr(2, OP_SHR, 8'h00);
		queueInstr(3, OP_SHR, 8'h00); // last bit out, acc zero
		queueInstr(4, OP_HLT, 8'h00);
		runProgram();
		queueInstr(0, OP_LDI, 8'h0F);
		queueInstr(1, OP_OR, 8'h81);
		queueInstr(2, OP_AND, 8'h80);
		queueInstr(3, OP_XOR, 8'h82);
		queueInstr(4, OP_HLT, 8'h00);
		queueByte(8'h80, 8'hF0);
		queueByte(8'h81, 8'h3C);
		queueByte(8'h82, 8'h30);
		runProgram();
		queueInstr(0, OP_LDI, 8'hA5); // store to result, then store and read back
		queueInstr(1, OP_STA, 8'(`UP_RESULT_ADDR));
		queueInstr(2, OP_LDI, 8'h5C);
		queueInstr(3, OP_STA, 8'h90);
		queueInstr(4, OP_LDI, 8'h00);
		queueInstr(5, OP_LDA, 8'h90);
		queueInstr(6, OP_HLT, 8'h00);
		runProgram();
	endtask

	initial begin
		nRst     = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		resetAndBoot();
		directedPrograms();
		for (int p = 0; p < 40; p++) begin
			randomProgram();
			runProgram();
		end
		// reset partway through a loaded program
		randomProgram();
		loadProgram();
		repeat (4) @(negedge clk);
		resetAndBoot();
		$display("errors: %0d mismatches, %0d other failures", errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
+incdir+verif
rtl/upPkg.sv
rtl/upMemory.sv
rtl/upFetchUnit.sv
rtl/upAccumulator.sv
rtl/upSequencer.sv
rtl/upCpu.sv
verif/upCpuTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module upCpuTb -f verilog.f -o upCpuSim

./obj_dir/upCpuSim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
exit 0
